/* design/ffu_config.svh */
// Width and size macros for the floating-point frontend
// Included by the package and by every design file that sizes a port

`ifndef FFU_CONFIG_SVH
`define FFU_CONFIG_SVH

//////////////////////////////
// Data path
//////////////////////////////

`define FFU_DATA_W   64    // FRF entry and operand width

//////////////////////////////
// Register file
//////////////////////////////

`define FFU_REG_N    32    // Number of FRF entries
`define FFU_ADDR_W   5     // Register number width

//////////////////////////////
// Instruction fields
//////////////////////////////

`define FFU_OPF_W    9     // VIS opf field
`define FFU_ALIGN_W  3     // GSR align byte offset

`endif

/* design/ffu_pkg.sv */
// Shared types of the floating-point frontend
// Opcode and unit encodings plus the records passed between pipeline stages

`include "ffu_config.svh"

package ffu_pkg;

   // SPARC VIS opf values handled by the unit
   typedef enum logic [`FFU_OPF_W-1:0] {
      FALIGNDATA = 9'h048,
      FPADD16    = 9'h050,
      FPADD32    = 9'h052,
      FPSUB16    = 9'h054,
      FPSUB32    = 9'h056,
      FZERO      = 9'h060,
      FNOR       = 9'h062,
      FXOR       = 9'h06C,
      FNAND      = 9'h06E,
      FAND       = 9'h070,
      FOR        = 9'h07C,
      FONE       = 9'h07E
   } vis_opf_e;

   typedef enum logic [2:0] {
      ADD_UNIT, LOGIC_UNIT, ALIGN_UNIT, LOAD_UNIT, STORE_UNIT
   } exec_unit_e;

   typedef enum logic [2:0] {
      LOG_ZERO, LOG_ONE, LOG_AND, LOG_OR, LOG_XOR, LOG_NAND, LOG_NOR
   } logic_fn_e;

   //////////////////////////////
   // Pipeline records
   //////////////////////////////

   typedef struct packed {
      vis_opf_e                opf;
      logic [`FFU_ADDR_W-1:0]  rs1;
      logic [`FFU_ADDR_W-1:0]  rs2;
      logic [`FFU_ADDR_W-1:0]  rd;
      logic                    fld;       // Load into rd
      logic                    fst;       // Store from rd
   } ffu_inst_t;

   typedef struct packed {
      logic                    vld;
      logic                    ill;
      exec_unit_e              unit;
      logic                    add32;     // 32-bit lanes
      logic                    subtract;
      logic_fn_e               log_fn;
      logic [`FFU_ADDR_W-1:0]  rs1;
      logic [`FFU_ADDR_W-1:0]  rs2;
      logic [`FFU_ADDR_W-1:0]  rd;
      logic [`FFU_DATA_W-1:0]  ld_data;
   } dec_item_t;

   typedef struct packed {
      logic                    vld;
      logic                    ill;
      logic                    store;
      logic [`FFU_ADDR_W-1:0]  rd;
      logic [`FFU_DATA_W-1:0]  data;
   } ex_item_t;

   typedef struct packed {
      logic                    vld;
      logic                    ill;
      logic                    store;
      logic [`FFU_ADDR_W-1:0]  rd;
      logic [`FFU_DATA_W-1:0]  data;
   } ffu_done_t;

endpackage

/* design/ffu_decode.sv */
// Decode stage of the frontend pipeline
// Turns the issued instruction into a control item held for one cycle

`include "ffu_config.svh"

module ffu_decode (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  logic                    inst_vld,
   input  ffu_pkg::ffu_inst_t      inst,
   input  logic [`FFU_DATA_W-1:0]  ld_data,
   output ffu_pkg::dec_item_t      dec
);

   ffu_pkg::dec_item_t dec_nxt;
   ffu_pkg::dec_item_t item_q;     // Payload, no reset
   logic               vld_q;

   always_comb begin
      dec_nxt         = '0;
      dec_nxt.vld     = inst_vld;
      dec_nxt.unit    = ffu_pkg::LOGIC_UNIT;
      dec_nxt.log_fn  = ffu_pkg::LOG_ZERO;
      dec_nxt.rs1     = inst.rs1;
      dec_nxt.rs2     = inst.rs2;
      dec_nxt.rd      = inst.rd;
      dec_nxt.ld_data = ld_data;
      if (inst.fld) begin
         dec_nxt.unit = ffu_pkg::LOAD_UNIT;
      end else if (inst.fst) begin
         dec_nxt.unit = ffu_pkg::STORE_UNIT;
         dec_nxt.rs2  = inst.rd;             // Store reads the rd register
      end else begin
         case (inst.opf)
            ffu_pkg::FPADD16: dec_nxt.unit = ffu_pkg::ADD_UNIT;
            ffu_pkg::FPADD32: begin
               dec_nxt.unit  = ffu_pkg::ADD_UNIT;
               dec_nxt.add32 = 1'b1;
            end
            ffu_pkg::FPSUB16: begin
               dec_nxt.unit     = ffu_pkg::ADD_UNIT;
               dec_nxt.subtract = 1'b1;
            end
            ffu_pkg::FPSUB32: begin
               dec_nxt.unit     = ffu_pkg::ADD_UNIT;
               dec_nxt.add32    = 1'b1;
               dec_nxt.subtract = 1'b1;
            end
            ffu_pkg::FALIGNDATA: dec_nxt.unit = ffu_pkg::ALIGN_UNIT;
            ffu_pkg::FZERO:      dec_nxt.log_fn = ffu_pkg::LOG_ZERO;
            ffu_pkg::FONE:       dec_nxt.log_fn = ffu_pkg::LOG_ONE;
            ffu_pkg::FAND:       dec_nxt.log_fn = ffu_pkg::LOG_AND;
            ffu_pkg::FOR:        dec_nxt.log_fn = ffu_pkg::LOG_OR;
            ffu_pkg::FXOR:       dec_nxt.log_fn = ffu_pkg::LOG_XOR;
            ffu_pkg::FNAND:      dec_nxt.log_fn = ffu_pkg::LOG_NAND;
            ffu_pkg::FNOR:       dec_nxt.log_fn = ffu_pkg::LOG_NOR;
            default:             dec_nxt.ill = 1'b1;   // Not a VIS op we know
         endcase
      end
   end

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= dec_nxt.vld;
      end
   end

   always_ff @(posedge rclk) begin
      item_q <= dec_nxt;
   end

   always_comb begin
      dec     = item_q;
      dec.vld = vld_q;
   end

endmodule

/* design/ffu_regfile.sv */
// Floating-point register file, 32 entries of 64 bits
// Two asynchronous read ports for the execute stage, one write port from result

`include "ffu_config.svh"

module ffu_regfile (
   input  logic                    rclk,
   input  logic [`FFU_ADDR_W-1:0]  rd1_addr,
   input  logic [`FFU_ADDR_W-1:0]  rd2_addr,
   output logic [`FFU_DATA_W-1:0]  rd1_data,
   output logic [`FFU_DATA_W-1:0]  rd2_data,
   input  logic                    wen,
   input  logic [`FFU_ADDR_W-1:0]  waddr,
   input  logic [`FFU_DATA_W-1:0]  wdata
);

   logic [`FFU_DATA_W-1:0] frf_mem [`FFU_REG_N];    // Contents undefined until loaded

   //////////////////////////////
   // Read ports
   //////////////////////////////

   assign rd1_data = frf_mem[rd1_addr];
   assign rd2_data = frf_mem[rd2_addr];   // Also the store read

   //////////////////////////////
   // Write port
   //////////////////////////////

   always_ff @(posedge rclk) begin
      if (wen) begin
         frf_mem[waddr] <= wdata;
      end
   end

endmodule

/* design/ffu_vis_execute.sv */
// Execute stage with operand bypass and the VIS data path
// Partitioned adder, logic unit and byte aligner feed the execute register

`include "ffu_config.svh"

module ffu_vis_execute (
   input  logic                     rclk,
   input  logic                     rst_n,
   input  ffu_pkg::dec_item_t       dec,
   input  logic [`FFU_DATA_W-1:0]   rd1_data,
   input  logic [`FFU_DATA_W-1:0]   rd2_data,
   input  logic [`FFU_ALIGN_W-1:0]  gsr_align,
   output ffu_pkg::ex_item_t        ex
);

   logic [`FFU_DATA_W-1:0]   op1;
   logic [`FFU_DATA_W-1:0]   op2;
   logic                     ex_writes;      // Item ahead will write the FRF
   logic [`FFU_DATA_W-1:0]   add_res;
   logic [`FFU_DATA_W-1:0]   log_res;
   logic [2*`FFU_DATA_W-1:0] align_cat;
   logic [`FFU_DATA_W-1:0]   ex_data_nxt;
   ffu_pkg::ex_item_t        item_q;
   logic                     vld_q;

   //////////////////////////////
   // Operand bypass
   //////////////////////////////

   assign ex_writes = ex.vld && !ex.ill && !ex.store;
   assign op1 = (ex_writes && ex.rd == dec.rs1) ? ex.data : rd1_data;
   assign op2 = (ex_writes && ex.rd == dec.rs2) ? ex.data : rd2_data;

   //////////////////////////////
   // Partitioned adder
   //////////////////////////////

   // Four 16-bit lanes; for 32-bit ops the odd lanes take the carry below
   always_comb begin
      logic [16:0] lane_sum;
      logic [15:0] lane_b;
      logic        lane_cin;
      logic        carry;
      carry   = 1'b0;
      add_res = '0;
      for (int i = 0; i < 4; i++) begin
         lane_b   = dec.subtract ? ~op2[i*16 +: 16] : op2[i*16 +: 16];
         lane_cin = (dec.add32 && i[0]) ? carry : dec.subtract;
         lane_sum = {1'b0, op1[i*16 +: 16]} + {1'b0, lane_b} + {16'd0, lane_cin};
         add_res[i*16 +: 16] = lane_sum[15:0];
         carry    = lane_sum[16];
      end
   end

   //////////////////////////////
   // Logic unit and aligner
   //////////////////////////////

   always_comb begin
      case (dec.log_fn)
         ffu_pkg::LOG_ONE:  log_res = '1;
         ffu_pkg::LOG_AND:  log_res = op1 & op2;
         ffu_pkg::LOG_OR:   log_res = op1 | op2;
         ffu_pkg::LOG_XOR:  log_res = op1 ^ op2;
         ffu_pkg::LOG_NAND: log_res = ~(op1 & op2);
         ffu_pkg::LOG_NOR:  log_res = ~(op1 | op2);
         default:           log_res = '0;
      endcase
   end

   // Drop gsr_align bytes off the top of rs1:rs2, keep the upper 64 bits
   assign align_cat = {op1, op2} << {gsr_align, 3'b000};

   always_comb begin
      case (dec.unit)
         ffu_pkg::ADD_UNIT:   ex_data_nxt = add_res;
         ffu_pkg::ALIGN_UNIT: ex_data_nxt = align_cat[2*`FFU_DATA_W-1 -: `FFU_DATA_W];
         ffu_pkg::LOAD_UNIT:  ex_data_nxt = dec.ld_data;
         ffu_pkg::STORE_UNIT: ex_data_nxt = op2;       // Store operand
         default:             ex_data_nxt = log_res;
      endcase
   end

   //////////////////////////////
   // Execute register
   //////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= dec.vld;
      end
   end

   always_ff @(posedge rclk) begin
      item_q.vld   <= 1'b0;
      item_q.ill   <= dec.ill;
      item_q.store <= (dec.unit == ffu_pkg::STORE_UNIT);
      item_q.rd    <= dec.rd;
      item_q.data  <= ex_data_nxt;
   end

   always_comb begin
      ex     = item_q;
      ex.vld = vld_q;
   end

endmodule

/* design/ffu_result.sv */
// Result stage of the frontend pipeline
// Writes the FRF and holds the completion record for one cycle

`include "ffu_config.svh"

module ffu_result (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  ffu_pkg::ex_item_t       ex,
   output logic                    wen,
   output logic [`FFU_ADDR_W-1:0]  waddr,
   output logic [`FFU_DATA_W-1:0]  wdata,
   output ffu_pkg::ffu_done_t      done
);

   ffu_pkg::ffu_done_t done_q;
   logic               vld_q;

   assign wen   = ex.vld && !ex.ill && !ex.store;   // Stores and bad ops leave FRF alone
   assign waddr = ex.rd;
   assign wdata = ex.data;

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= ex.vld;
      end
   end

   always_ff @(posedge rclk) begin
      done_q.vld   <= 1'b0;
      done_q.ill   <= ex.ill;
      done_q.store <= ex.store;
      done_q.rd    <= ex.rd;
      done_q.data  <= ex.ill ? '0 : ex.data;   // Illegal op returns zero
   end

   always_comb begin
      done     = done_q;
      done.vld = vld_q;
   end

endmodule

/* design/ffu_top.sv */
// Top level of the VIS floating-point frontend
// Decode, execute and result stages around the FRF, one instruction per clock

`include "ffu_config.svh"

module ffu_top (
   input  logic                     rclk,
   input  logic                     rst_n,
   input  logic                     inst_vld,
   input  ffu_pkg::ffu_inst_t       inst,
   input  logic [`FFU_DATA_W-1:0]   ld_data,
   input  logic [`FFU_ALIGN_W-1:0]  gsr_align,
   output ffu_pkg::ffu_done_t       done
);

   ffu_pkg::dec_item_t      dec;
   ffu_pkg::ex_item_t       ex;
   logic [`FFU_DATA_W-1:0]  rd1_data;
   logic [`FFU_DATA_W-1:0]  rd2_data;
   logic                    wen;
   logic [`FFU_ADDR_W-1:0]  waddr;
   logic [`FFU_DATA_W-1:0]  wdata;

   ffu_decode u_decode (
      .rclk     (rclk),
      .rst_n    (rst_n),
      .inst_vld (inst_vld),
      .inst     (inst),
      .ld_data  (ld_data),
      .dec      (dec)
   );

   ffu_regfile u_frf (
      .rclk     (rclk),
      .rd1_addr (dec.rs1),
      .rd2_addr (dec.rs2),        // Holds rd for stores
      .rd1_data (rd1_data),
      .rd2_data (rd2_data),
      .wen      (wen),
      .waddr    (waddr),
      .wdata    (wdata)
   );

   ffu_vis_execute u_vis (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .dec       (dec),
      .rd1_data  (rd1_data),
      .rd2_data  (rd2_data),
      .gsr_align (gsr_align),
      .ex        (ex)
   );

   ffu_result u_result (
      .rclk  (rclk),
      .rst_n (rst_n),
      .ex    (ex),
      .wen   (wen),
      .waddr (waddr),
      .wdata (wdata),
      .done  (done)
   );

endmodule

/* test/ffu_props.sv */
// Pipeline protocol properties of the frontend
// Bound into the top level and reports only through failing assertions

module ffu_props (
   input logic                rclk,
   input logic                rst_n,
   input logic                inst_vld,
   input ffu_pkg::ffu_inst_t  inst,
   input ffu_pkg::ffu_done_t  done,
   input logic                wen
);
   timeunit 1ns;
   timeprecision 1ps;

   logic bad_opf;   // Issued op outside the VIS set

   assign bad_opf = inst_vld && !inst.fld && !inst.fst &&
                    !(inst.opf inside {ffu_pkg::FALIGNDATA, ffu_pkg::FPADD16,
                                       ffu_pkg::FPADD32, ffu_pkg::FPSUB16,
                                       ffu_pkg::FPSUB32, ffu_pkg::FZERO,
                                       ffu_pkg::FNOR, ffu_pkg::FXOR,
                                       ffu_pkg::FNAND, ffu_pkg::FAND,
                                       ffu_pkg::FOR, ffu_pkg::FONE});

   // Three samples after an accepted instruction, and at no other time
   done_follows_issue: assert property (@(posedge rclk) disable iff (!rst_n)
      done.vld == $past(inst_vld, 3))
      else $error("done.vld does not track inst_vld through the pipeline");

   // Write slot of a bad op stays closed, then it completes as illegal
   no_write_on_illegal: assert property (@(posedge rclk) disable iff (!rst_n)
      bad_opf |-> ##2 !wen ##1 done.ill)
      else $error("Illegal instruction wrote the FRF or was not flagged");

   idle_after_reset: assert property (@(posedge rclk)
      $rose(rst_n) |-> !done.vld)
      else $error("done.vld high right after reset");

endmodule

bind ffu_top ffu_props u_props (
   .rclk     (rclk),
   .rst_n    (rst_n),
   .inst_vld (inst_vld),
   .inst     (inst),
   .done     (done),
   .wen      (wen)
);

/* test/ffu_tb.sv */
// Directed testbench for the VIS floating-point frontend
// A shadow FRF model predicts every completion, and a collector checks done

`include "ffu_config.svh"

module ffu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 40;
   localparam int INST_COUNT  = 150;   // Instructions over all tests
   localparam int DRAIN_COUNT = 16;    // Pipeline drains over all tests
   localparam int WATCHDOG_NS = 2 * (INST_COUNT + 4 * DRAIN_COUNT + 10) * CLK_PERIOD;

   logic                     rclk;
   logic                     rst_n;
   logic                     inst_vld;
   ffu_pkg::ffu_inst_t       inst;
   logic [`FFU_DATA_W-1:0]   ld_data;
   logic [`FFU_ALIGN_W-1:0]  gsr_align;
   ffu_pkg::ffu_done_t       done;

   logic [63:0]              shadow_frf [32];   // Program-order FRF model
   ffu_pkg::ffu_done_t       exp_q [$];
   int                       due_q [$];         // Cycle each result is due
   int                       cyc;
   int                       errors;
   int                       checks;
   logic [31:0]              lcg_state;

   ffu_top u_dut (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .inst_vld  (inst_vld),
      .inst      (inst),
      .ld_data   (ld_data),
      .gsr_align (gsr_align),
      .done      (done)
   );

   initial begin
      rclk = 1'b0;
      forever #(CLK_PERIOD / 2) rclk = ~rclk;
   end

   always @(posedge rclk) begin
      cyc = cyc + 1;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [63:0] rand64();
      logic [31:0] hi;
      hi = lcg_next();
      return {hi, lcg_next()};
   endfunction

   // Per-lane wrap, lanes never see each other's carries
   function automatic logic [63:0] lane_arith(input logic [63:0] a, input logic [63:0] b,
                                              input bit sub, input bit wide);
      logic [63:0] r;
      r = '0;
      if (wide) begin
         for (int i = 0; i < 2; i++) begin
            r[i*32 +: 32] = sub ? a[i*32 +: 32] - b[i*32 +: 32] : a[i*32 +: 32] + b[i*32 +: 32];
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            r[i*16 +: 16] = sub ? a[i*16 +: 16] - b[i*16 +: 16] : a[i*16 +: 16] + b[i*16 +: 16];
         end
      end
      return r;
   endfunction

   //////////////////////////////
   // Issue and reference model
   //////////////////////////////

   task automatic run_inst(input logic [8:0] opf, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [4:0] rd, input logic fld, input logic fst,
                           input logic [63:0] ldv);
      ffu_pkg::ffu_done_t e;
      logic [127:0]       cat;
      logic [63:0]        a;
      logic [63:0]        b;
      @(negedge rclk);
      inst_vld  = 1'b1;
      inst.opf  = ffu_pkg::vis_opf_e'(opf);
      inst.rs1  = rs1;
      inst.rs2  = rs2;
      inst.rd   = rd;
      inst.fld  = fld;
      inst.fst  = fst;
      ld_data   = ldv;
      a         = shadow_frf[rs1];
      b         = shadow_frf[rs2];
      cat       = {a, b};
      e         = '0;
      e.vld     = 1'b1;
      e.rd      = rd;
      if (fld) begin
         e.data = ldv;
      end else if (fst) begin
         e.store = 1'b1;
         e.data  = shadow_frf[rd];
      end else begin
         case (opf)
            ffu_pkg::FPADD16:    e.data = lane_arith(a, b, 1'b0, 1'b0);
            ffu_pkg::FPADD32:    e.data = lane_arith(a, b, 1'b0, 1'b1);
            ffu_pkg::FPSUB16:    e.data = lane_arith(a, b, 1'b1, 1'b0);
            ffu_pkg::FPSUB32:    e.data = lane_arith(a, b, 1'b1, 1'b1);
            ffu_pkg::FALIGNDATA: e.data = cat[127 - 8 * int'(gsr_align) -: 64];
            ffu_pkg::FZERO:      e.data = '0;
            ffu_pkg::FONE:       e.data = '1;
            ffu_pkg::FAND:       e.data = a & b;
            ffu_pkg::FOR:        e.data = a | b;
            ffu_pkg::FXOR:       e.data = a ^ b;
            ffu_pkg::FNAND:      e.data = ~(a & b);
            ffu_pkg::FNOR:       e.data = ~(a | b);
            default:             e.ill  = 1'b1;    // Data stays zero
         endcase
      end
      if (!e.ill && !e.store) begin
         shadow_frf[rd] = e.data;
      end
      exp_q.push_back(e);
      due_q.push_back(cyc + 3);    // Sampled at next edge, done two edges on
   endtask

   task automatic issue_op(input logic [8:0] opf, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [4:0] rd);
      run_inst(opf, rs1, rs2, rd, 1'b0, 1'b0, 64'd0);
   endtask

   task automatic issue_load(input logic [4:0] rd, input logic [63:0] value);
      run_inst(9'h000, 5'd0, 5'd0, rd, 1'b1, 1'b0, value);
   endtask

   task automatic issue_store(input logic [4:0] rd);
      run_inst(9'h000, 5'd0, 5'd0, rd, 1'b0, 1'b1, 64'd0);
   endtask

   task automatic drain();
      @(negedge rclk);
      inst_vld = 1'b0;
      while (exp_q.size() != 0) @(negedge rclk);
   endtask

   //////////////////////////////
   // Result collector
   //////////////////////////////

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   always @(negedge rclk) begin : collect
      ffu_pkg::ffu_done_t exp_rec;
      logic               due_now;
      if (rst_n) begin
         due_now = (due_q.size() != 0) && (due_q[0] == cyc);
         check_val("done.vld", 64'(done.vld), 64'(due_now));
         if (due_now) begin
            exp_rec = exp_q.pop_front();
            void'(due_q.pop_front());
            if (done.vld) begin
               check_val("done.ill", 64'(done.ill), 64'(exp_rec.ill));
               check_val("done.store", 64'(done.store), 64'(exp_rec.store));
               check_val("done.rd", 64'(done.rd), 64'(exp_rec.rd));
               check_val("done.data", done.data, exp_rec.data);
            end
         end
      end
   end

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic load_store_test();
      for (int r = 0; r < 32; r++) begin
         issue_load(r[4:0], rand64());
      end
      for (int r = 31; r >= 0; r--) begin   // Store r31 right behind its load
         issue_store(r[4:0]);
      end
      drain();
   endtask

   task automatic add_sub_test();
      for (int n = 0; n < 4; n++) begin
         if (n == 0) begin
            issue_load(5'd1, 64'hFFFF_8000_7FFF_FFFF);   // Every lane overflows
            issue_load(5'd2, 64'h0001_8000_8001_0001);
         end else begin
            issue_load(5'd1, rand64());
            issue_load(5'd2, rand64());
         end
         issue_op(ffu_pkg::FPADD16, 5'd1, 5'd2, 5'd10);
         issue_op(ffu_pkg::FPADD32, 5'd1, 5'd2, 5'd11);
         issue_op(ffu_pkg::FPSUB16, 5'd2, 5'd1, 5'd12);
         issue_op(ffu_pkg::FPSUB32, 5'd2, 5'd1, 5'd13);
         for (int r = 10; r < 14; r++) begin
            issue_store(r[4:0]);
         end
      end
      drain();
   endtask

   task automatic logic_test();
      logic [8:0] ops [7];
      ops = '{ffu_pkg::FZERO, ffu_pkg::FONE, ffu_pkg::FAND, ffu_pkg::FOR,
              ffu_pkg::FXOR, ffu_pkg::FNAND, ffu_pkg::FNOR};
      issue_load(5'd3, rand64());
      issue_load(5'd4, rand64());
      for (int i = 0; i < 7; i++) begin
         issue_op(ops[i], 5'd3, 5'd4, 5'(20 + i));
         issue_store(5'(20 + i));
      end
      drain();
   endtask

   task automatic align_test();
      issue_load(5'd6, rand64());
      issue_load(5'd7, rand64());
      for (int a = 0; a < 8; a++) begin
         drain();                             // GSR only changes when idle
         gsr_align = a[2:0];
         issue_op(ffu_pkg::FALIGNDATA, 5'd6, 5'd7, 5'd5);
         issue_store(5'd5);
      end
      drain();
   endtask

   task automatic bypass_test();
      issue_load(5'd8, rand64());
      issue_op(ffu_pkg::FPADD16, 5'd8, 5'd8, 5'd9);    // Load data one ahead
      issue_op(ffu_pkg::FPADD32, 5'd9, 5'd8, 5'd10);
      issue_op(ffu_pkg::FXOR, 5'd10, 5'd9, 5'd11);     // One and two ahead
      issue_op(ffu_pkg::FPSUB16, 5'd11, 5'd10, 5'd12);
      issue_op(9'h1FF, 5'd11, 5'd11, 5'd11);           // Undefined opf
      issue_op(ffu_pkg::FOR, 5'd11, 5'd12, 5'd13);     // Ignores the bad item
      issue_store(5'd11);
      issue_store(5'd12);
      issue_store(5'd13);
      drain();
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired with %0d results still outstanding", exp_q.size());
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst_n     = 1'b0;
      inst_vld  = 1'b0;
      inst      = '0;
      ld_data   = '0;
      gsr_align = '0;
      cyc       = 0;
      errors    = 0;
      checks    = 0;
      lcg_state = 32'h84f8;
      repeat (3) @(posedge rclk);
      @(negedge rclk);
      rst_n = 1'b1;
      load_store_test();
      add_sub_test();
      logic_test();
      align_test();
      bypass_test();
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("Results still missing at the end of the run");
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+design
design/ffu_pkg.sv
design/ffu_decode.sv
design/ffu_regfile.sv
design/ffu_vis_execute.sv
design/ffu_result.sv
design/ffu_top.sv
test/ffu_props.sv
test/ffu_tb.sv

/* run.sh */
#!/bin/sh
# Compile the frontend testbench with Verilator and run it
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f list.f --top-module ffu_tb \
      -Mdir obj_dir -o ffu_sim \
   && ./obj_dir/ffu_sim | tee /dev/stderr | grep -q "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
